// ==== bench/hero_ooc_assert.sv ====
`default_nettype none

module hero_ooc_assert #(
  parameter int unsigned N_CLUSTERS = 4
) (
  input wire                  clk_i,
  input wire                  rst_n_i,
  input wire                  mst_ar_valid_o,
  input wire                  mst_ar_ready_i,
  input wire [31:0]           mst_ar_addr_o,
  input wire                  mst_aw_valid_o,
  input wire                  mst_aw_ready_i,
  input wire [31:0]           mst_aw_addr_o,
  input wire [N_CLUSTERS-1:0] cl_eoc_o,
  input wire [N_CLUSTERS-1:0] cl_busy_o,
  input wire                  cfg_b_valid_o,
  input wire                  cfg_b_ready_i
);

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_addr_o))
    else $error("AR valid dropped or address changed before ready");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_addr_o))
    else $error("AW valid dropped or address changed before ready");

  // eoc is a single pulse in the cycle in which busy falls
  eoc_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cl_eoc_o & (cl_busy_o | ~$past(cl_busy_o) | $past(cl_eoc_o))) == '0)
    else $error("eoc not a single pulse at the fall of busy");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o)
    else $error("Config B valid dropped before ready");

endmodule

bind hero_ooc hero_ooc_assert #(.N_CLUSTERS(N_CLUSTERS)) i_assert (.*);

`default_nettype wire

// ==== bench/hero_ooc_tb.sv ====
`default_nettype none

module hero_ooc_tb import hero_axi_pkg::*; ();

  localparam int unsigned N  = 4;
  localparam int unsigned DW = 32;
  localparam int unsigned IW = 2;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic [N-1:0] cl_fetch_en_i, cl_eoc_o, cl_busy_o;
  logic [IW-1:0] mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  logic [31:0] mst_aw_addr_o, mst_ar_addr_o;
  logic [DW-1:0] mst_w_data_o, mst_r_data_i;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic mst_r_valid_i, mst_r_ready_o;
  resp_t mst_b_resp_i, mst_r_resp_i, cfg_b_resp_o, cfg_r_resp_o;
  logic [31:0] cfg_aw_addr_i, cfg_w_data_i, cfg_ar_addr_i, cfg_r_data_o;
  logic [3:0] cfg_w_strb_i;
  logic cfg_aw_valid_i, cfg_aw_ready_o, cfg_w_valid_i, cfg_w_ready_o;
  logic cfg_b_valid_o, cfg_b_ready_i, cfg_ar_valid_i, cfg_ar_ready_o;
  logic cfg_r_valid_o, cfg_r_ready_i;

  // Host memory model state
  logic [31:0] mem_q [logic [31:0]];
  logic        bad_q [logic [31:0]];
  logic [31:0] obs_rd[$], exp_rd[$];
  logic [63:0] obs_wr[$], exp_wr[$];
  logic [IW-1:0] r_id_q[$], b_id_q[$];
  logic [DW-1:0] r_data_q[$];
  resp_t       r_resp_q[$];
  logic        aw_got, w_got;
  logic [31:0] aw_addr_h;
  logic [IW-1:0] aw_id_h;
  logic [DW-1:0] w_data_h;
  int          r_wait, b_wait;
  int          eoc_cnt [N];
  int          cfg_errs, mst_errs, eoc_errs;
  string       lines[$];
  logic        loaded = 1'b0;

  hero_ooc #(.N_CLUSTERS(N), .AXI_DW(DW), .NUM_SLICES(4)) UUT (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    for (int c = 0; c < N; c++) begin
      if (cl_eoc_o[c]) eoc_cnt[c]++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host memory on the master port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (mst_r_valid_i && !mst_r_ready_o) begin
        $display("ERROR mst_r_ready_o got %h exp 1", mst_r_ready_o);
        mst_errs++;
      end
      if (mst_b_valid_i && !mst_b_ready_o) begin
        $display("ERROR mst_b_ready_o got %h exp 1", mst_b_ready_o);
        mst_errs++;
      end
      mst_ar_ready_i <= ($urandom % 3) != 0;
      mst_aw_ready_i <= ($urandom % 3) != 0;
      mst_w_ready_i  <= ($urandom % 3) != 0;
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        obs_rd.push_back(mst_ar_addr_o);
        r_id_q.push_back(mst_ar_id_o);
        // Unwritten words read back a pattern of their address
        r_data_q.push_back(mem_q.exists(mst_ar_addr_o) ? mem_q[mst_ar_addr_o]
                                                        : mst_ar_addr_o ^ 32'h5A5A_A5A5);
        r_resp_q.push_back(bad_q.exists(mst_ar_addr_o) ? RESP_SLVERR : RESP_OKAY);
      end
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        aw_got    = 1'b1;
        aw_addr_h = mst_aw_addr_o;
        aw_id_h   = mst_aw_id_o;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        w_got    = 1'b1;
        w_data_h = mst_w_data_o;
      end
      if (aw_got && w_got) begin
        mem_q[aw_addr_h] = w_data_h;
        obs_wr.push_back({aw_addr_h, w_data_h});
        b_id_q.push_back(aw_id_h);
        aw_got = 1'b0;
        w_got  = 1'b0;
      end
      mst_r_valid_i <= 1'b0;
      if (r_id_q.size() > 0) begin
        if (r_wait > 0) begin
          r_wait--;
        end else begin
          mst_r_valid_i <= 1'b1;
          mst_r_id_i    <= r_id_q.pop_front();
          mst_r_data_i  <= r_data_q.pop_front();
          mst_r_resp_i  <= r_resp_q.pop_front();
          r_wait = $urandom % 4;
        end
      end
      mst_b_valid_i <= 1'b0;
      if (b_id_q.size() > 0) begin
        if (b_wait > 0) begin
          b_wait--;
        end else begin
          mst_b_valid_i <= 1'b1;
          mst_b_id_i    <= b_id_q.pop_front();
          mst_b_resp_i  <= RESP_OKAY;
          b_wait = $urandom % 4;
        end
      end
    end
  end

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    @(posedge clk_i);
    cfg_aw_addr_i  <= addr;
    cfg_w_data_i   <= data;
    cfg_aw_valid_i <= 1'b1;
    cfg_w_valid_i  <= 1'b1;
    do @(posedge clk_i); while (!cfg_aw_ready_o);
    if (!cfg_w_ready_o) begin
      $display("ERROR cfg_w_ready_o addr %h got %h exp 1", addr, cfg_w_ready_o);
      cfg_errs++;
    end
    cfg_aw_valid_i <= 1'b0;
    cfg_w_valid_i  <= 1'b0;
    do @(posedge clk_i); while (!cfg_b_valid_o);
    // B is left waiting a few cycles before it is taken
    repeat ($urandom % 3) @(posedge clk_i);
    cfg_b_ready_i <= 1'b1;
    @(posedge clk_i);
    cfg_b_ready_i <= 1'b0;
    if (cfg_b_resp_o != exp_resp) begin
      $display("ERROR cfg_b_resp_o addr %h got %h exp %h", addr, cfg_b_resp_o, exp_resp);
      cfg_errs++;
    end
  endtask

  task automatic cfg_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    @(posedge clk_i);
    cfg_ar_addr_i  <= addr;
    cfg_ar_valid_i <= 1'b1;
    do @(posedge clk_i); while (!cfg_ar_ready_o);
    cfg_ar_valid_i <= 1'b0;
    do @(posedge clk_i); while (!cfg_r_valid_o);
    repeat ($urandom % 3) @(posedge clk_i);
    cfg_r_ready_i <= 1'b1;
    @(posedge clk_i);
    cfg_r_ready_i <= 1'b0;
    if (!cfg_r_valid_o) begin
      $display("Config R valid dropped before ready at address %h", addr);
      cfg_errs++;
    end
    if (cfg_r_data_o != exp_data) begin
      $display("ERROR cfg_r_data_o addr %h got %h exp %h", addr, cfg_r_data_o, exp_data);
      cfg_errs++;
    end
    if (cfg_r_resp_o != exp_resp) begin
      $display("ERROR cfg_r_resp_o addr %h got %h exp %h", addr, cfg_r_resp_o, exp_resp);
      cfg_errs++;
    end
  endtask

  function automatic logic jobs_done(input logic [N-1:0] mask);
    for (int c = 0; c < N; c++) begin
      if (mask[c] && eoc_cnt[c] == 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Start the masked clusters, then match master traffic in any order
  task automatic run_jobs(input logic [N-1:0] mask);
    int idx[$];
    for (int c = 0; c < N; c++) eoc_cnt[c] = 0;
    @(posedge clk_i);
    cl_fetch_en_i <= mask;
    // Busy is up one cycle after fetch enable is seen
    repeat (2) @(posedge clk_i);
    if (cl_busy_o != mask) begin
      $display("ERROR cl_busy_o got %h exp %h", cl_busy_o, mask);
      eoc_errs++;
    end
    while (!jobs_done(mask)) @(posedge clk_i);
    cl_fetch_en_i <= '0;
    repeat (8) @(posedge clk_i);
    for (int c = 0; c < N; c++) begin
      if (eoc_cnt[c] != (mask[c] ? 1 : 0)) begin
        $display("ERROR cl_eoc_o[%0d] pulses got %h exp %h", c, eoc_cnt[c], mask[c]);
        eoc_errs++;
      end
    end
    foreach (exp_rd[i]) begin
      idx = obs_rd.find_first_index(x) with (x == exp_rd[i]);
      if (idx.size() == 0) begin
        $display("ERROR mst_ar_addr_o exp %h not seen", exp_rd[i]);
        mst_errs++;
      end else obs_rd.delete(idx[0]);
    end
    foreach (exp_wr[i]) begin
      idx = obs_wr.find_first_index(x) with (x == exp_wr[i]);
      if (idx.size() == 0) begin
        $display("ERROR mst_aw_addr_o/mst_w_data_o exp %h not seen", exp_wr[i]);
        mst_errs++;
      end else obs_wr.delete(idx[0]);
    end
    foreach (obs_rd[i]) begin
      $display("ERROR mst_ar_addr_o unexpected %h", obs_rd[i]);
      mst_errs++;
    end
    foreach (obs_wr[i]) begin
      $display("ERROR mst_aw_addr_o/mst_w_data_o unexpected %h", obs_wr[i]);
      mst_errs++;
    end
    obs_rd.delete();
    obs_wr.delete();
    exp_rd.delete();
    exp_wr.delete();
  endtask

  initial begin
    wait (loaded);
    #((lines.size() + 4) * 1000);
    $display("Watchdog expired before the test list finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int fd;
    string line;
    byte cmd;
    logic [31:0] a, b, c;
    void'($urandom(98951));
    {rst_n_i, cl_fetch_en_i, cfg_aw_valid_i, cfg_w_valid_i, cfg_ar_valid_i} = '0;
    {cfg_aw_addr_i, cfg_w_data_i, cfg_ar_addr_i} = '0;
    cfg_w_strb_i = 4'hF;
    cfg_b_ready_i = 1'b0;
    cfg_r_ready_i = 1'b0;
    {mst_aw_ready_i, mst_w_ready_i, mst_ar_ready_i, mst_b_valid_i, mst_r_valid_i} = '0;
    {mst_b_id_i, mst_r_id_i, mst_b_resp_i, mst_r_resp_i, mst_r_data_i} = '0;
    {aw_got, w_got, r_wait, b_wait, cfg_errs, mst_errs, eoc_errs} = '0;
    fd = $fopen("bench/hero_ooc_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test list");
      cfg_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (lines[i]) begin
      {a, b, c} = '0;
      void'($sscanf(lines[i], "%c %h %h %h", cmd, a, b, c));
      case (cmd)
        "W": cfg_write(a, b, c[1:0]);
        "R": cfg_read(a, b, c[1:0]);
        "P": mem_q[a] = b;
        "E": bad_q[a] = 1'b1;
        "A": exp_rd.push_back(a);
        "X": exp_wr.push_back({a, b});
        "F": run_jobs(a[N-1:0]);
        default: begin
          $display("Unknown command in test list line %0d", i);
          cfg_errs++;
        end
      endcase
    end
    $display("Errors: config %0d, master %0d, eoc %0d", cfg_errs, mst_errs, eoc_errs);
    if (cfg_errs + mst_errs + eoc_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/hero_ooc_tests.txt ====
# W addr data resp: config write | R addr data resp: config read | P addr data: preload
# E addr: read error | A addr: exp read | X addr data: exp write | F mask: run clusters
W 00000000 10000000 0
W 00000004 100000FF 0
W 00000008 80000000 0
W 0000000C 00000001 0
R 00000000 10000000 0
R 00000004 100000FF 0
R 00000008 80000000 0
R 0000000C 00000001 0
R 00000040 00000000 2
W 00000044 12345678 2
P 80000000 00000011
A 80000000
X 80000004 00000012
F 1
W 00000010 10000000 0
W 00000014 10000FFF 0
W 00000018 90000000 0
W 0000001C 00000001 0
R 00000018 90000000 0
P 90000100 00000020
P 90000200 00000030
P 90000300 00000040
A 80000000
A 90000100
A 90000200
A 90000300
X 80000004 00000012
X 90000104 00000022
X 90000204 00000033
X 90000304 00000044
F F
W 0000001C 00000000 0
F 2
E 80000000
A 80000000
F 1

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hero_ooc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hero_ooc_tb \
  -f src.f -o hero_ooc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/hero_ooc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^All tests passed$"; then
  exit 0
fi
exit 1

// ==== src.f ====
verilog/hero_axi_pkg.sv
verilog/hero_cfg_pkg.sv
verilog/hero_mem_if.sv
verilog/cluster_job.sv
verilog/cluster_arbiter.sv
verilog/rab_cfg_regs.sv
verilog/rab_translate.sv
verilog/hero_ooc.sv
bench/hero_ooc_assert.sv
bench/hero_ooc_tb.sv

// ==== verilog/cluster_arbiter.sv ====
`default_nettype none

module cluster_arbiter import hero_axi_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 4,
  parameter int unsigned AXI_DW     = 32
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  hero_mem_if.responder cl [N_CLUSTERS],
  hero_mem_if.requester down
);

  localparam int unsigned IW = axi_iw(N_CLUSTERS);

  logic [N_CLUSTERS-1:0] req_v;
  logic [N_CLUSTERS-1:0] req_wr;
  logic [IW-1:0]         req_id    [N_CLUSTERS];
  logic [AXI_AW-1:0]     req_addr  [N_CLUSTERS];
  logic [AXI_DW-1:0]     req_wdata [N_CLUSTERS];
  logic [IW-1:0]         rr_q;
  logic [IW-1:0]         gnt_idx;
  logic                  gnt_found;

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : g_cl
    assign req_v[i]     = cl[i].req_valid;
    assign req_wr[i]    = cl[i].req_write;
    assign req_id[i]    = cl[i].req_id;
    assign req_addr[i]  = cl[i].req_addr;
    assign req_wdata[i] = cl[i].req_wdata;

    assign cl[i].req_ready = down.req_ready && gnt_found && (gnt_idx == IW'(i));

    // Responses go to every cluster, only the owner sees valid
    assign cl[i].rsp_valid = down.rsp_valid && (down.rsp_id == IW'(i));
    assign cl[i].rsp_id    = down.rsp_id;
    assign cl[i].rsp_rdata = down.rsp_rdata;
    assign cl[i].rsp_err   = down.rsp_err;
  end

  // First valid request at or after the pointer
  always_comb begin
    logic [IW-1:0] idx;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 0; k < N_CLUSTERS; k++) begin
      idx = IW'((32'(rr_q) + k) % N_CLUSTERS);
      if (!gnt_found && req_v[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (gnt_found && down.req_ready) begin
      rr_q <= (gnt_idx == IW'(N_CLUSTERS - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  assign down.req_valid = gnt_found;
  assign down.req_write = req_wr[gnt_idx];
  assign down.req_id    = req_id[gnt_idx];
  assign down.req_addr  = req_addr[gnt_idx];
  assign down.req_wdata = req_wdata[gnt_idx];

endmodule

`default_nettype wire

// ==== verilog/cluster_job.sv ====
`default_nettype none

module cluster_job import hero_axi_pkg::*, hero_cfg_pkg::*; #(
  parameter int unsigned AXI_DW = 32,
  parameter int unsigned CL_IDX = 0
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          fetch_en_i,
  output logic          busy_o,
  output logic          eoc_o,
  hero_mem_if.requester mem
);

  localparam int unsigned IW = $bits(mem.req_id);
  localparam logic [AXI_AW-1:0] VA = JOB_VA_BASE + CL_IDX * JOB_VA_STRIDE;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_WAIT_RD,
    S_WRITE,
    S_WAIT_WR,
    S_DONE,
    S_REARM
  } state_e;

  state_e            state_q;
  logic [AXI_DW-1:0] wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_en_i) state_q <= S_READ;
        end
        S_READ: begin
          if (mem.req_ready) state_q <= S_WAIT_RD;
        end
        S_WAIT_RD: begin
          // A failed read ends the job without a write
          if (mem.rsp_valid) state_q <= mem.rsp_err ? S_DONE : S_WRITE;
        end
        S_WRITE: begin
          if (mem.req_ready) state_q <= S_WAIT_WR;
        end
        S_WAIT_WR: begin
          if (mem.rsp_valid) state_q <= S_DONE;
        end
        S_DONE: begin
          state_q <= S_REARM;
        end
        default: begin
          // Wait for fetch enable to drop before the next run
          if (!fetch_en_i) state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_WAIT_RD && mem.rsp_valid) begin
      wdata_q <= mem.rsp_rdata + AXI_DW'(CL_IDX + 1);
    end
  end

  assign mem.req_valid = (state_q == S_READ) || (state_q == S_WRITE);
  assign mem.req_write = (state_q == S_WRITE);
  assign mem.req_id    = IW'(CL_IDX);
  assign mem.req_addr  = mem.req_write ? VA + 32'd4 : VA;
  assign mem.req_wdata = wdata_q;

  assign busy_o = (state_q == S_READ) || (state_q == S_WAIT_RD) ||
                  (state_q == S_WRITE) || (state_q == S_WAIT_WR);
  assign eoc_o  = (state_q == S_DONE);

endmodule

`default_nettype wire

// ==== verilog/hero_axi_pkg.sv ====
`default_nettype none

package hero_axi_pkg;

  // Master port address width, one word
  localparam int unsigned AXI_AW = 32;

  // Configuration port widths
  localparam int unsigned LITE_AW = 32;
  localparam int unsigned LITE_DW = 32;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ID width for a given cluster count, never below one bit
  function automatic int unsigned axi_iw(input int unsigned n_clusters);
    int unsigned w;
    w = $clog2(n_clusters);
    return (w < 1) ? 1 : w;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/hero_cfg_pkg.sv ====
`default_nettype none

package hero_cfg_pkg;

  // One RAB slice, bounds are inclusive
  typedef struct packed {
    logic [31:0] first;
    logic [31:0] last;
    logic [31:0] offset;
    logic        en;
  } rab_slice_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned SLICE_STRIDE = 16;

  localparam logic [3:0] REG_FIRST  = 4'h0;
  localparam logic [3:0] REG_LAST   = 4'h4;
  localparam logic [3:0] REG_OFFSET = 4'h8;
  localparam logic [3:0] REG_EN     = 4'hC;

  // Fixed cluster job
  localparam logic [31:0] JOB_VA_BASE   = 32'h1000_0000;
  localparam logic [31:0] JOB_VA_STRIDE = 32'h100;

endpackage

`default_nettype wire

// ==== verilog/hero_mem_if.sv ====
`default_nettype none

interface hero_mem_if import hero_axi_pkg::*; #(
  parameter int unsigned AXI_DW = 32,
  parameter int unsigned IW     = 1
);

  logic              req_valid;
  logic              req_ready;
  logic              req_write;
  logic [IW-1:0]     req_id;
  logic [AXI_AW-1:0] req_addr;
  logic [AXI_DW-1:0] req_wdata;

  // One-cycle response pulse, never stalled
  logic              rsp_valid;
  logic [IW-1:0]     rsp_id;
  logic [AXI_DW-1:0] rsp_rdata;
  logic              rsp_err;

  modport requester (
    output req_valid, req_write, req_id, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_id, rsp_rdata, rsp_err
  );

  modport responder (
    input  req_valid, req_write, req_id, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_id, rsp_rdata, rsp_err
  );

endinterface

`default_nettype wire

// ==== verilog/hero_ooc.sv ====
`default_nettype none

module hero_ooc import hero_axi_pkg::*, hero_cfg_pkg::*; #(
  parameter  int unsigned N_CLUSTERS = 4,
  parameter  int unsigned AXI_DW     = 32,
  parameter  int unsigned NUM_SLICES = 4,
  localparam int unsigned IW         = axi_iw(N_CLUSTERS)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Cluster control
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,

  // External master port
  output logic [IW-1:0]         mst_aw_id_o,
  output logic [AXI_AW-1:0]     mst_aw_addr_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output logic [AXI_DW-1:0]     mst_w_data_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  logic [IW-1:0]         mst_b_id_i,
  input  resp_t                 mst_b_resp_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  output logic [IW-1:0]         mst_ar_id_o,
  output logic [AXI_AW-1:0]     mst_ar_addr_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  logic [IW-1:0]         mst_r_id_i,
  input  logic [AXI_DW-1:0]     mst_r_data_i,
  input  resp_t                 mst_r_resp_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o,

  // RAB configuration port
  input  logic [LITE_AW-1:0]    cfg_aw_addr_i,
  input  logic                  cfg_aw_valid_i,
  output logic                  cfg_aw_ready_o,
  input  logic [LITE_DW-1:0]    cfg_w_data_i,
  input  logic [LITE_DW/8-1:0]  cfg_w_strb_i,
  input  logic                  cfg_w_valid_i,
  output logic                  cfg_w_ready_o,
  output resp_t                 cfg_b_resp_o,
  output logic                  cfg_b_valid_o,
  input  logic                  cfg_b_ready_i,
  input  logic [LITE_AW-1:0]    cfg_ar_addr_i,
  input  logic                  cfg_ar_valid_i,
  output logic                  cfg_ar_ready_o,
  output logic [LITE_DW-1:0]    cfg_r_data_o,
  output resp_t                 cfg_r_resp_o,
  output logic                  cfg_r_valid_o,
  input  logic                  cfg_r_ready_i
);

  hero_mem_if #(.AXI_DW(AXI_DW), .IW(IW)) cl_if [N_CLUSTERS] ();
  hero_mem_if #(.AXI_DW(AXI_DW), .IW(IW)) rab_if ();

  rab_slice_t slices [NUM_SLICES];

  for (genvar c = 0; c < N_CLUSTERS; c++) begin : g_cluster
    cluster_job #(
      .AXI_DW (AXI_DW),
      .CL_IDX (c)
    ) i_job (
      .clk_i,
      .rst_n_i,
      .fetch_en_i (cl_fetch_en_i[c]),
      .busy_o     (cl_busy_o[c]),
      .eoc_o      (cl_eoc_o[c]),
      .mem        (cl_if[c])
    );
  end

  cluster_arbiter #(
    .N_CLUSTERS (N_CLUSTERS),
    .AXI_DW     (AXI_DW)
  ) i_arbiter (
    .clk_i,
    .rst_n_i,
    .cl   (cl_if),
    .down (rab_if)
  );

  rab_cfg_regs #(
    .NUM_SLICES (NUM_SLICES)
  ) i_cfg_regs (
    .clk_i,
    .rst_n_i,
    .cfg_aw_addr_i,
    .cfg_aw_valid_i,
    .cfg_aw_ready_o,
    .cfg_w_data_i,
    .cfg_w_strb_i,
    .cfg_w_valid_i,
    .cfg_w_ready_o,
    .cfg_b_resp_o,
    .cfg_b_valid_o,
    .cfg_b_ready_i,
    .cfg_ar_addr_i,
    .cfg_ar_valid_i,
    .cfg_ar_ready_o,
    .cfg_r_data_o,
    .cfg_r_resp_o,
    .cfg_r_valid_o,
    .cfg_r_ready_i,
    .slices_o (slices)
  );

  rab_translate #(
    .NUM_SLICES (NUM_SLICES),
    .AXI_DW     (AXI_DW),
    .IW         (IW)
  ) i_translate (
    .clk_i,
    .rst_n_i,
    .req      (rab_if),
    .slices_i (slices),
    .mst_aw_id_o,
    .mst_aw_addr_o,
    .mst_aw_valid_o,
    .mst_aw_ready_i,
    .mst_w_data_o,
    .mst_w_valid_o,
    .mst_w_ready_i,
    .mst_b_id_i,
    .mst_b_resp_i,
    .mst_b_valid_i,
    .mst_b_ready_o,
    .mst_ar_id_o,
    .mst_ar_addr_o,
    .mst_ar_valid_o,
    .mst_ar_ready_i,
    .mst_r_id_i,
    .mst_r_data_i,
    .mst_r_resp_i,
    .mst_r_valid_i,
    .mst_r_ready_o
  );

endmodule

`default_nettype wire

// ==== verilog/rab_cfg_regs.sv ====
`default_nettype none

module rab_cfg_regs import hero_axi_pkg::*, hero_cfg_pkg::*; #(
  parameter int unsigned NUM_SLICES = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [LITE_AW-1:0]   cfg_aw_addr_i,
  input  logic                 cfg_aw_valid_i,
  output logic                 cfg_aw_ready_o,
  input  logic [LITE_DW-1:0]   cfg_w_data_i,
  input  logic [LITE_DW/8-1:0] cfg_w_strb_i,
  input  logic                 cfg_w_valid_i,
  output logic                 cfg_w_ready_o,
  output resp_t                cfg_b_resp_o,
  output logic                 cfg_b_valid_o,
  input  logic                 cfg_b_ready_i,
  input  logic [LITE_AW-1:0]   cfg_ar_addr_i,
  input  logic                 cfg_ar_valid_i,
  output logic                 cfg_ar_ready_o,
  output logic [LITE_DW-1:0]   cfg_r_data_o,
  output resp_t                cfg_r_resp_o,
  output logic                 cfg_r_valid_o,
  input  logic                 cfg_r_ready_i,
  output rab_slice_t           slices_o [NUM_SLICES]
);

  localparam int unsigned SW = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;
  localparam logic [LITE_AW-1:0] CFG_END = LITE_AW'(NUM_SLICES * SLICE_STRIDE);

  rab_slice_t         slices_q [NUM_SLICES];
  logic               b_valid_q;
  logic               r_valid_q;
  resp_t              b_resp_q;
  resp_t              r_resp_q;
  logic [LITE_DW-1:0] r_data_q;
  logic [LITE_DW-1:0] rd_value;
  logic               wr_fire;
  logic               rd_fire;
  logic               wr_in_range;
  logic               rd_in_range;
  logic [SW-1:0]      wr_slice;
  logic [SW-1:0]      rd_slice;

  function automatic logic [LITE_DW-1:0] merge_strb(input logic [LITE_DW-1:0] old_v,
                                                    input logic [LITE_DW-1:0] new_v,
                                                    input logic [LITE_DW/8-1:0] strb);
    logic [LITE_DW-1:0] res;
    res = old_v;
    for (int b = 0; b < LITE_DW / 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  // AW and W are taken together, one write in flight
  assign wr_fire     = cfg_aw_valid_i && cfg_w_valid_i && !b_valid_q;
  assign rd_fire     = cfg_ar_valid_i && !r_valid_q;
  assign wr_in_range = cfg_aw_addr_i < CFG_END;
  assign rd_in_range = cfg_ar_addr_i < CFG_END;
  assign wr_slice    = cfg_aw_addr_i[SW+3:4];
  assign rd_slice    = cfg_ar_addr_i[SW+3:4];

  always_comb begin
    rd_value = '0;
    if (rd_in_range) begin
      case ({cfg_ar_addr_i[3:2], 2'b00})
        REG_FIRST:  rd_value = slices_q[rd_slice].first;
        REG_LAST:   rd_value = slices_q[rd_slice].last;
        REG_OFFSET: rd_value = slices_q[rd_slice].offset;
        default:    rd_value = {{(LITE_DW-1){1'b0}}, slices_q[rd_slice].en};
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < NUM_SLICES; s++) slices_q[s] <= '0;
    end else if (wr_fire && wr_in_range) begin
      case ({cfg_aw_addr_i[3:2], 2'b00})
        REG_FIRST: slices_q[wr_slice].first <=
            merge_strb(slices_q[wr_slice].first, cfg_w_data_i, cfg_w_strb_i);
        REG_LAST: slices_q[wr_slice].last <=
            merge_strb(slices_q[wr_slice].last, cfg_w_data_i, cfg_w_strb_i);
        REG_OFFSET: slices_q[wr_slice].offset <=
            merge_strb(slices_q[wr_slice].offset, cfg_w_data_i, cfg_w_strb_i);
        default: begin
          if (cfg_w_strb_i[0]) slices_q[wr_slice].en <= cfg_w_data_i[0];
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // B and R responses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) b_valid_q <= 1'b1;
      else if (cfg_b_ready_i) b_valid_q <= 1'b0;
      if (rd_fire) r_valid_q <= 1'b1;
      else if (cfg_r_ready_i) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    if (rd_fire) begin
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= rd_value;
    end
  end

  assign cfg_aw_ready_o = wr_fire;
  assign cfg_w_ready_o  = wr_fire;
  assign cfg_b_valid_o  = b_valid_q;
  assign cfg_b_resp_o   = b_resp_q;
  assign cfg_ar_ready_o = !r_valid_q;
  assign cfg_r_valid_o  = r_valid_q;
  assign cfg_r_resp_o   = r_resp_q;
  assign cfg_r_data_o   = r_data_q;
  assign slices_o       = slices_q;

endmodule

`default_nettype wire

// ==== verilog/rab_translate.sv ====
`default_nettype none

module rab_translate import hero_axi_pkg::*, hero_cfg_pkg::*; #(
  parameter int unsigned NUM_SLICES = 4,
  parameter int unsigned AXI_DW     = 32,
  parameter int unsigned IW         = 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  hero_mem_if.responder     req,
  input  rab_slice_t        slices_i [NUM_SLICES],
  output logic [IW-1:0]     mst_aw_id_o,
  output logic [AXI_AW-1:0] mst_aw_addr_o,
  output logic              mst_aw_valid_o,
  input  logic              mst_aw_ready_i,
  output logic [AXI_DW-1:0] mst_w_data_o,
  output logic              mst_w_valid_o,
  input  logic              mst_w_ready_i,
  input  logic [IW-1:0]     mst_b_id_i,
  input  resp_t             mst_b_resp_i,
  input  logic              mst_b_valid_i,
  output logic              mst_b_ready_o,
  output logic [IW-1:0]     mst_ar_id_o,
  output logic [AXI_AW-1:0] mst_ar_addr_o,
  output logic              mst_ar_valid_o,
  input  logic              mst_ar_ready_i,
  input  logic [IW-1:0]     mst_r_id_i,
  input  logic [AXI_DW-1:0] mst_r_data_i,
  input  resp_t             mst_r_resp_i,
  input  logic              mst_r_valid_i,
  output logic              mst_r_ready_o
);

  localparam int unsigned NSLOT = 2 ** IW;

  logic              hit;
  logic [AXI_AW-1:0] phys_addr;
  logic              grant;
  logic              ar_valid_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              miss_q;
  logic [IW-1:0]     id_q;
  logic [AXI_AW-1:0] addr_q;
  logic [AXI_DW-1:0] wdata_q;
  logic [NSLOT-1:0]  in_v;
  logic [NSLOT-1:0]  in_err;
  logic [NSLOT-1:0]  cand;
  logic [NSLOT-1:0]  pend_q;
  logic [NSLOT-1:0]  perr_q;
  logic [AXI_DW-1:0] pdata_q [NSLOT];
  logic [IW-1:0]     sel;

  // Descending scan so the lowest hitting slice wins
  always_comb begin
    hit       = 1'b0;
    phys_addr = '0;
    for (int s = NUM_SLICES - 1; s >= 0; s--) begin
      if (slices_i[s].en && req.req_addr >= slices_i[s].first &&
          req.req_addr <= slices_i[s].last) begin
        hit       = 1'b1;
        phys_addr = req.req_addr - slices_i[s].first + slices_i[s].offset;
      end
    end
  end

  assign req.req_ready = !(ar_valid_q || aw_valid_q || w_valid_q);
  assign grant         = req.req_valid && req.req_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      miss_q     <= 1'b0;
    end else begin
      miss_q <= grant && !hit;
      if (grant && hit && !req.req_write) ar_valid_q <= 1'b1;
      else if (mst_ar_ready_i) ar_valid_q <= 1'b0;
      if (grant && hit && req.req_write) aw_valid_q <= 1'b1;
      else if (mst_aw_ready_i) aw_valid_q <= 1'b0;
      if (grant && hit && req.req_write) w_valid_q <= 1'b1;
      else if (mst_w_ready_i) w_valid_q <= 1'b0;
    end
  end

  // The ID also tags the miss error in the next cycle
  always_ff @(posedge clk_i) begin
    if (grant) begin
      id_q    <= req.req_id;
      addr_q  <= phys_addr;
      wdata_q <= req.req_wdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response merge, one slot per ID
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    in_v   = '0;
    in_err = '0;
    if (mst_r_valid_i) begin
      in_v[mst_r_id_i]   = 1'b1;
      in_err[mst_r_id_i] = (mst_r_resp_i != RESP_OKAY);
    end
    if (mst_b_valid_i) begin
      in_v[mst_b_id_i]   = 1'b1;
      in_err[mst_b_id_i] = (mst_b_resp_i != RESP_OKAY);
    end
    if (miss_q) begin
      in_v[id_q]   = 1'b1;
      in_err[id_q] = 1'b1;
    end
    cand = pend_q | in_v;
    sel  = '0;
    for (int k = NSLOT - 1; k >= 0; k--) begin
      if (cand[k]) sel = IW'(k);
    end
  end

  // Colliding responses wait a few cycles in their slot
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) pend_q <= '0;
    else pend_q <= cand & ~(NSLOT'(1) << sel);
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NSLOT; k++) begin
      if (in_v[k] && !pend_q[k]) begin
        pdata_q[k] <= mst_r_data_i;
        perr_q[k]  <= in_err[k];
      end
    end
  end

  assign req.rsp_valid = |cand;
  assign req.rsp_id    = sel;
  assign req.rsp_rdata = pend_q[sel] ? pdata_q[sel] : mst_r_data_i;
  assign req.rsp_err   = pend_q[sel] ? perr_q[sel] : in_err[sel];

  assign mst_ar_id_o    = id_q;
  assign mst_ar_addr_o  = addr_q;
  assign mst_ar_valid_o = ar_valid_q;
  assign mst_aw_id_o    = id_q;
  assign mst_aw_addr_o  = addr_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_data_o   = wdata_q;
  assign mst_w_valid_o  = w_valid_q;
  assign mst_b_ready_o  = 1'b1;
  assign mst_r_ready_o  = 1'b1;

endmodule

`default_nettype wire
